/* Makefile */
# Verilator build and run of the LSU sharing network testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_port_share
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
logic/lsu_cfg_pkg.sv
logic/ldst_pkg.sv
logic/fair_2way_arbiter.sv
logic/vaddr_adder.sv
logic/vadder_share.sv
logic/dcache_share.sv
logic/lsu_port_share.sv
testbench/tb_lsu_port_share.sv

/* logic/dcache_share.sv */
/*
 * Sharing of the L1 data cache port between load and store buffers:
 * arbiter, request mux, store width encoding, answer and wakeup decoder
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_share (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 lb_dcache_valid_i,
  input  logic                                 sb_dcache_valid_i,
  input  logic                                 dcache_ready_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         lb_paddr_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_paddr_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_value_i,
  input  ldst_pkg::ldst_type_e                 sb_dc_sttype_i,
  input  logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] lb_dc_tag_i,
  input  logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] sb_dc_tag_i,
  output logic                                 lb_dcache_ready_o,
  output logic                                 sb_dcache_ready_o,
  output logic                                 dcache_req_valid_o,
  output logic                                 dcache_req_is_store_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_req_paddr_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_req_data_o,
  output ldst_pkg::store_width_e               dcache_req_width_o,
  output lsu_cfg_pkg::buff_idx_u               dcache_req_idx_o,
  input  logic                                 dcache_ans_valid_i,
  input  logic                                 dcache_wup_valid_i,
  input  logic                                 dcache_was_store_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         dcache_ans_data_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         dcache_wup_line_i,
  input  lsu_cfg_pkg::buff_idx_u               dcache_ans_idx_i,
  input  logic                                 lb_dc_ans_ready_i,
  input  logic                                 sb_dc_ans_ready_i,
  output logic                                 lb_dc_ans_valid_o,
  output logic                                 sb_dc_ans_valid_o,
  output logic                                 lb_dc_wup_valid_o,
  output logic                                 sb_dc_wup_valid_o,
  output logic                                 dcache_ready_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_value_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_wup_line_o,
  output logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] lb_dc_ans_tag_o,
  output logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] sb_dc_ans_tag_o
);

  import ldst_pkg::*;

  logic sel_lb;

  // --------------------
  // Request side

  fair_2way_arbiter u_dcache_arb (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .lb_valid_i(lb_dcache_valid_i),
    .sb_valid_i(sb_dcache_valid_i),
    .ready_i   (dcache_ready_i),
    .valid_o   (dcache_req_valid_o),
    .lb_ready_o(lb_dcache_ready_o),
    .sb_ready_o(sb_dcache_ready_o),
    .lb_sel_o  (sel_lb)
  );

  assign dcache_req_is_store_o = ~sel_lb;

  always_comb begin
    dcache_req_idx_o = '0;
    if (sel_lb) begin
      dcache_req_paddr_o      = lb_paddr_i;
      dcache_req_data_o       = '0;
      dcache_req_width_o      = DW;
      dcache_req_idx_o.ld.tag = lb_dc_tag_i;
    end else begin
      dcache_req_paddr_o      = sb_paddr_i;
      dcache_req_data_o       = sb_value_i;
      dcache_req_idx_o.st.tag = sb_dc_tag_i;
      // Signedness does not matter for a write
      case (sb_dc_sttype_i)
        LS_BYTE, LS_BYTE_U:         dcache_req_width_o = B;
        LS_HALFWORD, LS_HALFWORD_U: dcache_req_width_o = HW;
        LS_WORD, LS_WORD_U:         dcache_req_width_o = W;
        default:                    dcache_req_width_o = DW;
      endcase
    end
  end

  // --------------------
  // Answers and wakeups

  assign lb_dc_ans_valid_o = dcache_ans_valid_i & ~dcache_was_store_i;
  assign sb_dc_ans_valid_o = dcache_ans_valid_i & dcache_was_store_i;
  assign lb_dc_wup_valid_o = dcache_wup_valid_i & ~dcache_was_store_i;
  assign sb_dc_wup_valid_o = dcache_wup_valid_i & dcache_was_store_i;
  assign dcache_ready_o    = dcache_was_store_i ? sb_dc_ans_ready_i : lb_dc_ans_ready_i;

  assign dcache_value_o    = dcache_ans_data_i;
  assign dcache_wup_line_o = dcache_wup_line_i;
  assign lb_dc_ans_tag_o   = dcache_ans_idx_i.ld.tag;
  assign sb_dc_ans_tag_o   = dcache_ans_idx_i.st.tag;

  // Cache side never answers and wakes up in the same cycle
  a_ans_wup_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dcache_ans_valid_i && dcache_wup_valid_i));

endmodule

`default_nettype wire

/* logic/fair_2way_arbiter.sv */
/*
 * Round-robin handshake arbiter between the load buffer
 * and the store buffer for one shared resource
 */
`timescale 1ns/1ps
`default_nettype none

module fair_2way_arbiter (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic lb_valid_i,
  input  logic sb_valid_i,
  input  logic ready_i,
  output logic valid_o,
  output logic lb_ready_o,
  output logic sb_ready_o,
  output logic lb_sel_o
);

  // High when the load side won the last transfer
  logic last_lb_q;

  // Load side wins alone, or on a tie when the store side went last
  assign lb_sel_o   = lb_valid_i & (~sb_valid_i | ~last_lb_q);
  assign valid_o    = lb_valid_i | sb_valid_i;
  assign lb_ready_o = ready_i & lb_sel_o;
  assign sb_ready_o = ready_i & sb_valid_i & ~lb_sel_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_lb_q <= 1'b1;
    end else if (valid_o && ready_i) begin
      last_lb_q <= lb_sel_o;
    end
  end

  // A contested grant goes to the side not served at the last transfer
  a_alternate : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && ready_i |=>
      !(lb_valid_i && sb_valid_i) || lb_sel_o != $past(lb_sel_o));

endmodule

`default_nettype wire

/* logic/ldst_pkg.sv */
/*
 * Operation encodings of the load/store unit:
 * access types, cache store widths and exception codes
 */
`default_nettype none

package ldst_pkg;

  localparam int unsigned LDST_TYPE_LEN = 3;
  localparam int unsigned ST_WIDTH_LEN  = 2;
  localparam int unsigned EXCEPT_LEN    = 4;

  // Access type from the decode stage
  typedef enum logic [LDST_TYPE_LEN-1:0] {
    LS_BYTE,
    LS_BYTE_U,
    LS_HALFWORD,
    LS_HALFWORD_U,
    LS_WORD,
    LS_WORD_U,
    LS_DOUBLEWORD
  } ldst_type_e;

  // Width of a cache write
  typedef enum logic [ST_WIDTH_LEN-1:0] {
    B,
    HW,
    W,
    DW
  } store_width_e;

  // Codes follow the RISC-V mcause numbering
  typedef enum logic [EXCEPT_LEN-1:0] {
    E_NONE               = 4'd0,
    E_LD_ADDR_MISALIGNED = 4'd4,
    E_ST_ADDR_MISALIGNED = 4'd6
  } except_e;

endpackage

`default_nettype wire

/* logic/lsu_cfg_pkg.sv */
/*
 * Data width and buffer tag sizes of the load/store unit,
 * plus the shared buffer index seen as a load tag or a store tag
 */
`default_nettype none

package lsu_cfg_pkg;

  localparam int unsigned XLEN         = 64;
  localparam int unsigned LDBUFF_TAG_W = 3;
  localparam int unsigned STBUFF_TAG_W = 2;

  // Shared index is as wide as the larger tag
  localparam int unsigned BUFF_IDX_LEN =
      (LDBUFF_TAG_W > STBUFF_TAG_W) ? LDBUFF_TAG_W : STBUFF_TAG_W;

  // Load tags span the whole index, so no padding in this view
  typedef struct packed {
    logic [LDBUFF_TAG_W-1:0] tag;
  } ld_idx_t;

  typedef struct packed {
    logic [BUFF_IDX_LEN-STBUFF_TAG_W-1:0] pad;
    logic [STBUFF_TAG_W-1:0]              tag;
  } st_idx_t;

  // Decoded by the store flag that travels with it
  typedef union packed {
    ld_idx_t ld;
    st_idx_t st;
  } buff_idx_u;

endpackage

`default_nettype wire

/* logic/lsu_port_share.sv */
/*
 * Load/store unit resource sharing: address adder path
 * and data cache path between the two buffers
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_port_share (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 flush_i,
  // Address adder
  input  logic                                 lb_vadder_valid_i,
  input  logic                                 sb_vadder_valid_i,
  input  logic                                 lb_vadder_ready_i,
  input  logic                                 sb_vadder_ready_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         lb_rs1_value_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         lb_imm_value_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_rs1_value_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_imm_value_i,
  input  ldst_pkg::ldst_type_e                 lb_ldtype_i,
  input  ldst_pkg::ldst_type_e                 sb_sttype_i,
  input  logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] lb_tag_i,
  input  logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] sb_tag_i,
  output logic                                 lb_vadder_ready_o,
  output logic                                 sb_vadder_ready_o,
  output logic                                 vadder_lb_valid_o,
  output logic                                 vadder_sb_valid_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         vadder_vaddr_o,
  output ldst_pkg::except_e                    vadder_except_o,
  output logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] vadder_lb_tag_o,
  output logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] vadder_sb_tag_o,
  // Data cache requests
  input  logic                                 lb_dcache_valid_i,
  input  logic                                 sb_dcache_valid_i,
  input  logic                                 dcache_ready_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         lb_paddr_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_paddr_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_value_i,
  input  ldst_pkg::ldst_type_e                 sb_dc_sttype_i,
  input  logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] lb_dc_tag_i,
  input  logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] sb_dc_tag_i,
  output logic                                 lb_dcache_ready_o,
  output logic                                 sb_dcache_ready_o,
  output logic                                 dcache_req_valid_o,
  output logic                                 dcache_req_is_store_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_req_paddr_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_req_data_o,
  output ldst_pkg::store_width_e               dcache_req_width_o,
  output lsu_cfg_pkg::buff_idx_u               dcache_req_idx_o,
  // Data cache answers and wakeups
  input  logic                                 dcache_ans_valid_i,
  input  logic                                 dcache_wup_valid_i,
  input  logic                                 dcache_was_store_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         dcache_ans_data_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         dcache_wup_line_i,
  input  lsu_cfg_pkg::buff_idx_u               dcache_ans_idx_i,
  input  logic                                 lb_dc_ans_ready_i,
  input  logic                                 sb_dc_ans_ready_i,
  output logic                                 lb_dc_ans_valid_o,
  output logic                                 sb_dc_ans_valid_o,
  output logic                                 lb_dc_wup_valid_o,
  output logic                                 sb_dc_wup_valid_o,
  output logic                                 dcache_ready_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_value_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         dcache_wup_line_o,
  output logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] lb_dc_ans_tag_o,
  output logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] sb_dc_ans_tag_o
);

  vadder_share u_vadder_share (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .lb_vadder_valid_i(lb_vadder_valid_i),
    .sb_vadder_valid_i(sb_vadder_valid_i),
    .lb_vadder_ready_i(lb_vadder_ready_i),
    .sb_vadder_ready_i(sb_vadder_ready_i),
    .lb_rs1_value_i   (lb_rs1_value_i),
    .lb_imm_value_i   (lb_imm_value_i),
    .sb_rs1_value_i   (sb_rs1_value_i),
    .sb_imm_value_i   (sb_imm_value_i),
    .lb_ldtype_i      (lb_ldtype_i),
    .sb_sttype_i      (sb_sttype_i),
    .lb_tag_i         (lb_tag_i),
    .sb_tag_i         (sb_tag_i),
    .lb_vadder_ready_o(lb_vadder_ready_o),
    .sb_vadder_ready_o(sb_vadder_ready_o),
    .vadder_lb_valid_o(vadder_lb_valid_o),
    .vadder_sb_valid_o(vadder_sb_valid_o),
    .vadder_vaddr_o   (vadder_vaddr_o),
    .vadder_except_o  (vadder_except_o),
    .vadder_lb_tag_o  (vadder_lb_tag_o),
    .vadder_sb_tag_o  (vadder_sb_tag_o)
  );

  dcache_share u_dcache_share (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .lb_dcache_valid_i    (lb_dcache_valid_i),
    .sb_dcache_valid_i    (sb_dcache_valid_i),
    .dcache_ready_i       (dcache_ready_i),
    .lb_paddr_i           (lb_paddr_i),
    .sb_paddr_i           (sb_paddr_i),
    .sb_value_i           (sb_value_i),
    .sb_dc_sttype_i       (sb_dc_sttype_i),
    .lb_dc_tag_i          (lb_dc_tag_i),
    .sb_dc_tag_i          (sb_dc_tag_i),
    .lb_dcache_ready_o    (lb_dcache_ready_o),
    .sb_dcache_ready_o    (sb_dcache_ready_o),
    .dcache_req_valid_o   (dcache_req_valid_o),
    .dcache_req_is_store_o(dcache_req_is_store_o),
    .dcache_req_paddr_o   (dcache_req_paddr_o),
    .dcache_req_data_o    (dcache_req_data_o),
    .dcache_req_width_o   (dcache_req_width_o),
    .dcache_req_idx_o     (dcache_req_idx_o),
    .dcache_ans_valid_i   (dcache_ans_valid_i),
    .dcache_wup_valid_i   (dcache_wup_valid_i),
    .dcache_was_store_i   (dcache_was_store_i),
    .dcache_ans_data_i    (dcache_ans_data_i),
    .dcache_wup_line_i    (dcache_wup_line_i),
    .dcache_ans_idx_i     (dcache_ans_idx_i),
    .lb_dc_ans_ready_i    (lb_dc_ans_ready_i),
    .sb_dc_ans_ready_i    (sb_dc_ans_ready_i),
    .lb_dc_ans_valid_o    (lb_dc_ans_valid_o),
    .sb_dc_ans_valid_o    (sb_dc_ans_valid_o),
    .lb_dc_wup_valid_o    (lb_dc_wup_valid_o),
    .sb_dc_wup_valid_o    (sb_dc_wup_valid_o),
    .dcache_ready_o       (dcache_ready_o),
    .dcache_value_o       (dcache_value_o),
    .dcache_wup_line_o    (dcache_wup_line_o),
    .lb_dc_ans_tag_o      (lb_dc_ans_tag_o),
    .sb_dc_ans_tag_o      (sb_dc_ans_tag_o)
  );

endmodule

`default_nettype wire

/* logic/vadder_share.sv */
/*
 * Sharing of the address adder between load and store buffers:
 * arbiter, operand mux and result decoder
 */
`timescale 1ns/1ps
`default_nettype none

module vadder_share (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 flush_i,
  input  logic                                 lb_vadder_valid_i,
  input  logic                                 sb_vadder_valid_i,
  input  logic                                 lb_vadder_ready_i,
  input  logic                                 sb_vadder_ready_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         lb_rs1_value_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         lb_imm_value_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_rs1_value_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0]         sb_imm_value_i,
  input  ldst_pkg::ldst_type_e                 lb_ldtype_i,
  input  ldst_pkg::ldst_type_e                 sb_sttype_i,
  input  logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] lb_tag_i,
  input  logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] sb_tag_i,
  output logic                                 lb_vadder_ready_o,
  output logic                                 sb_vadder_ready_o,
  output logic                                 vadder_lb_valid_o,
  output logic                                 vadder_sb_valid_o,
  output logic [lsu_cfg_pkg::XLEN-1:0]         vadder_vaddr_o,
  output ldst_pkg::except_e                    vadder_except_o,
  output logic [lsu_cfg_pkg::LDBUFF_TAG_W-1:0] vadder_lb_tag_o,
  output logic [lsu_cfg_pkg::STBUFF_TAG_W-1:0] vadder_sb_tag_o
);

  import lsu_cfg_pkg::*;
  import ldst_pkg::*;

  logic            arb_valid;
  logic            sel_lb;
  logic            adder_ready;
  logic [XLEN-1:0] mux_rs1;
  logic [XLEN-1:0] mux_imm;
  ldst_type_e      mux_type;
  buff_idx_u       mux_idx;
  logic            res_valid;
  logic            res_is_store;
  logic            res_ready;
  buff_idx_u       res_idx;

  // --------------------
  // Request side

  fair_2way_arbiter u_vadder_arb (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .lb_valid_i(lb_vadder_valid_i),
    .sb_valid_i(sb_vadder_valid_i),
    .ready_i   (adder_ready),
    .valid_o   (arb_valid),
    .lb_ready_o(lb_vadder_ready_o),
    .sb_ready_o(sb_vadder_ready_o),
    .lb_sel_o  (sel_lb)
  );

  always_comb begin
    mux_idx = '0;
    if (sel_lb) begin
      mux_rs1        = lb_rs1_value_i;
      mux_imm        = lb_imm_value_i;
      mux_type       = lb_ldtype_i;
      mux_idx.ld.tag = lb_tag_i;
    end else begin
      mux_rs1        = sb_rs1_value_i;
      mux_imm        = sb_imm_value_i;
      mux_type       = sb_sttype_i;
      mux_idx.st.tag = sb_tag_i;
    end
  end

  vaddr_adder u_vaddr_adder (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .valid_i    (arb_valid),
    .ready_i    (res_ready),
    .is_store_i (~sel_lb),
    .rs1_value_i(mux_rs1),
    .imm_value_i(mux_imm),
    .ldst_type_i(mux_type),
    .idx_i      (mux_idx),
    .valid_o    (res_valid),
    .ready_o    (adder_ready),
    .is_store_o (res_is_store),
    .vaddr_o    (vadder_vaddr_o),
    .idx_o      (res_idx),
    .except_o   (vadder_except_o)
  );

  // --------------------
  // Reply side

  assign vadder_lb_valid_o = res_valid & ~res_is_store;
  assign vadder_sb_valid_o = res_valid & res_is_store;
  assign res_ready         = res_is_store ? sb_vadder_ready_i : lb_vadder_ready_i;
  assign vadder_lb_tag_o   = res_idx.ld.tag;
  assign vadder_sb_tag_o   = res_idx.st.tag;

endmodule

`default_nettype wire

/* logic/vaddr_adder.sv */
/*
 * Virtual address adder with one output register and
 * alignment check on the computed address
 */
`timescale 1ns/1ps
`default_nettype none

module vaddr_adder (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  input  logic                         valid_i,
  input  logic                         ready_i,
  input  logic                         is_store_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0] rs1_value_i,
  input  logic [lsu_cfg_pkg::XLEN-1:0] imm_value_i,
  input  ldst_pkg::ldst_type_e         ldst_type_i,
  input  lsu_cfg_pkg::buff_idx_u       idx_i,
  output logic                         valid_o,
  output logic                         ready_o,
  output logic                         is_store_o,
  output logic [lsu_cfg_pkg::XLEN-1:0] vaddr_o,
  output lsu_cfg_pkg::buff_idx_u       idx_o,
  output ldst_pkg::except_e            except_o
);

  import lsu_cfg_pkg::*;
  import ldst_pkg::*;

  logic [XLEN-1:0] sum;
  logic            misaligned;
  except_e         except_d;
  logic            valid_q;

  assign sum = rs1_value_i + imm_value_i;

  always_comb begin
    case (ldst_type_i)
      LS_HALFWORD, LS_HALFWORD_U: misaligned = sum[0];
      LS_WORD, LS_WORD_U:         misaligned = |sum[1:0];
      LS_DOUBLEWORD:              misaligned = |sum[2:0];
      default:                    misaligned = 1'b0;
    endcase
    if (!misaligned) begin
      except_d = E_NONE;
    end else if (is_store_i) begin
      except_d = E_ST_ADDR_MISALIGNED;
    end else begin
      except_d = E_LD_ADDR_MISALIGNED;
    end
  end

  // Register can take a new request while the old result drains
  assign ready_o = ~valid_q | ready_i;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      vaddr_o    <= sum;
      idx_o      <= idx_i;
      is_store_o <= is_store_i;
      except_o   <= except_d;
    end
  end

  // Stalled result must not change under the consumer
  a_hold_result : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    valid_o && !ready_i |=> valid_o && $stable(vaddr_o) && $stable(idx_o)
      && $stable(is_store_o) && $stable(except_o));

endmodule

`default_nettype wire

/* testbench/tb_lsu_port_share.sv */
/*
 * Testbench for the load/store resource sharing network with
 * LFSR stimulus, a reference model of the grants and checks by assertions
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_port_share;

  import lsu_cfg_pkg::*;
  import ldst_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int TEST_CYCLES  = 3000;
  localparam int WATCHDOG_NS  = (TEST_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;
  localparam logic [15:0] LFSR_SEED = 16'd71;

  logic clk_i;
  logic rst_n_i;
  logic flush_i;
  // Address adder path
  logic lb_vadder_valid_i, sb_vadder_valid_i, lb_vadder_ready_i, sb_vadder_ready_i;
  logic [XLEN-1:0] lb_rs1_value_i, lb_imm_value_i, sb_rs1_value_i, sb_imm_value_i;
  ldst_type_e lb_ldtype_i, sb_sttype_i, sb_dc_sttype_i;
  logic [LDBUFF_TAG_W-1:0] lb_tag_i, lb_dc_tag_i, vadder_lb_tag_o, lb_dc_ans_tag_o;
  logic [STBUFF_TAG_W-1:0] sb_tag_i, sb_dc_tag_i, vadder_sb_tag_o, sb_dc_ans_tag_o;
  logic lb_vadder_ready_o, sb_vadder_ready_o, vadder_lb_valid_o, vadder_sb_valid_o;
  logic [XLEN-1:0] vadder_vaddr_o;
  except_e vadder_except_o;
  // Data cache path
  logic lb_dcache_valid_i, sb_dcache_valid_i, dcache_ready_i;
  logic [XLEN-1:0] lb_paddr_i, sb_paddr_i, sb_value_i;
  logic lb_dcache_ready_o, sb_dcache_ready_o, dcache_req_valid_o, dcache_req_is_store_o;
  logic [XLEN-1:0] dcache_req_paddr_o, dcache_req_data_o;
  store_width_e dcache_req_width_o;
  buff_idx_u dcache_req_idx_o, dcache_ans_idx_i;
  logic dcache_ans_valid_i, dcache_wup_valid_i, dcache_was_store_i;
  logic [XLEN-1:0] dcache_ans_data_i, dcache_wup_line_i, dcache_value_o, dcache_wup_line_o;
  logic lb_dc_ans_ready_i, sb_dc_ans_ready_i, dcache_ready_o;
  logic lb_dc_ans_valid_o, sb_dc_ans_valid_o, lb_dc_wup_valid_o, sb_dc_wup_valid_o;

  logic [15:0] lfsr_q;
  int          error_count;
  // Reference state of the grants and the completed transfers
  logic va_last_lb, dc_last_lb;
  logic lb_va_done, sb_va_done, lb_dc_done, sb_dc_done;
  logic va_exp_lb, dc_exp_lb, va_free;
  logic [XLEN-1:0] lb_sum, sb_sum, dc_exp_paddr;
  except_e lb_exc, sb_exc;
  logic [BUFF_IDX_LEN-1:0] dc_exp_idx;
  store_width_e dc_exp_width;

  lsu_port_share UUT (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    // x^16 + x^14 + x^13 + x^11 + 1
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic ldst_type_e pick_type(input logic [2:0] t);
    return (t == 3'd7) ? LS_DOUBLEWORD : ldst_type_e'(t);
  endfunction

  function automatic except_e misalign_code(input logic [XLEN-1:0] a, input ldst_type_e t,
                                            input logic st);
    logic bad;
    case (t)
      LS_HALFWORD, LS_HALFWORD_U: bad = a[0];
      LS_WORD, LS_WORD_U:         bad = a[1] | a[0];
      LS_DOUBLEWORD:              bad = a[2] | a[1] | a[0];
      default:                    bad = 1'b0;
    endcase
    if (!bad) return E_NONE;
    return st ? E_ST_ADDR_MISALIGNED : E_LD_ADDR_MISALIGNED;
  endfunction

  function automatic store_width_e width_code(input ldst_type_e t);
    case (t)
      LS_BYTE, LS_BYTE_U:         return B;
      LS_HALFWORD, LS_HALFWORD_U: return HW;
      LS_WORD, LS_WORD_U:         return W;
      default:                    return DW;
    endcase
  endfunction

  task automatic log_mismatch(input string what);
    error_count++;
    $display("ERROR at time %0t: %s", $time, what);
  endtask

  // --------------------
  // Reference model

  assign lb_sum       = lb_rs1_value_i + lb_imm_value_i;
  assign sb_sum       = sb_rs1_value_i + sb_imm_value_i;
  assign lb_exc       = misalign_code(lb_sum, lb_ldtype_i, 1'b0);
  assign sb_exc       = misalign_code(sb_sum, sb_sttype_i, 1'b1);
  assign va_exp_lb    = lb_vadder_valid_i && (!sb_vadder_valid_i || !va_last_lb);
  assign va_free      = !(vadder_lb_valid_o && !lb_vadder_ready_i)
                     && !(vadder_sb_valid_o && !sb_vadder_ready_i);
  assign dc_exp_lb    = lb_dcache_valid_i && (!sb_dcache_valid_i || !dc_last_lb);
  assign dc_exp_paddr = dc_exp_lb ? lb_paddr_i : sb_paddr_i;
  assign dc_exp_idx   = dc_exp_lb ? BUFF_IDX_LEN'(lb_dc_tag_i) : BUFF_IDX_LEN'(sb_dc_tag_i);
  assign dc_exp_width = dc_exp_lb ? DW : width_code(sb_dc_sttype_i);

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      va_last_lb <= 1'b1;
      dc_last_lb <= 1'b1;
      lb_va_done <= 1'b0;
      sb_va_done <= 1'b0;
      lb_dc_done <= 1'b0;
      sb_dc_done <= 1'b0;
    end else begin
      lb_va_done <= lb_vadder_valid_i && lb_vadder_ready_o;
      sb_va_done <= sb_vadder_valid_i && sb_vadder_ready_o;
      lb_dc_done <= lb_dcache_valid_i && lb_dcache_ready_o;
      sb_dc_done <= sb_dcache_valid_i && sb_dcache_ready_o;
      if (lb_vadder_valid_i && lb_vadder_ready_o) va_last_lb <= 1'b1;
      else if (sb_vadder_valid_i && sb_vadder_ready_o) va_last_lb <= 1'b0;
      if (lb_dcache_valid_i && lb_dcache_ready_o) dc_last_lb <= 1'b1;
      else if (sb_dcache_valid_i && sb_dcache_ready_o) dc_last_lb <= 1'b0;
    end
  end

  // --------------------
  // Checks

  a_lb_result : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lb_vadder_valid_i && lb_vadder_ready_o && !flush_i |=> vadder_lb_valid_o
      && !vadder_sb_valid_o && vadder_vaddr_o == $past(lb_sum)
      && vadder_except_o == $past(lb_exc) && vadder_lb_tag_o == $past(lb_tag_i))
    else log_mismatch("load side adder result");

  a_sb_result : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sb_vadder_valid_i && sb_vadder_ready_o && !flush_i |=> vadder_sb_valid_o
      && !vadder_lb_valid_o && vadder_vaddr_o == $past(sb_sum)
      && vadder_except_o == $past(sb_exc) && vadder_sb_tag_o == $past(sb_tag_i))
    else log_mismatch("store side adder result");

  // Adder ready needs the round-robin grant and a free result register
  a_va_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lb_vadder_ready_o == (va_free && va_exp_lb)
      && sb_vadder_ready_o == (va_free && sb_vadder_valid_i && !va_exp_lb))
    else log_mismatch("adder grant");

  a_va_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !va_free && !flush_i |=> $stable(vadder_lb_valid_o) && $stable(vadder_sb_valid_o)
      && $stable(vadder_vaddr_o) && $stable(vadder_except_o)
      && $stable(vadder_lb_tag_o) && $stable(vadder_sb_tag_o))
    else log_mismatch("stalled adder result changed");

  a_dc_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lb_dcache_ready_o == (dcache_ready_i && dc_exp_lb)
      && sb_dcache_ready_o == (dcache_ready_i && sb_dcache_valid_i && !dc_exp_lb))
    else log_mismatch("cache grant");

  a_dc_request : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dcache_req_valid_o == (lb_dcache_valid_i || sb_dcache_valid_i)
      && (!dcache_req_valid_o || (dcache_req_is_store_o == !dc_exp_lb
      && dcache_req_paddr_o == dc_exp_paddr && dcache_req_idx_o == dc_exp_idx
      && dcache_req_width_o == dc_exp_width
      && (dc_exp_lb || dcache_req_data_o == sb_value_i))))
    else log_mismatch("cache request fields");

  a_dc_answer : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dcache_ans_valid_i || dcache_wup_valid_i |->
      lb_dc_ans_valid_o == (dcache_ans_valid_i && !dcache_was_store_i)
      && sb_dc_ans_valid_o == (dcache_ans_valid_i && dcache_was_store_i)
      && lb_dc_wup_valid_o == (dcache_wup_valid_i && !dcache_was_store_i)
      && sb_dc_wup_valid_o == (dcache_wup_valid_i && dcache_was_store_i)
      && dcache_ready_o == (dcache_was_store_i ? sb_dc_ans_ready_i : lb_dc_ans_ready_i)
      && lb_dc_ans_tag_o == dcache_ans_idx_i[LDBUFF_TAG_W-1:0]
      && sb_dc_ans_tag_o == dcache_ans_idx_i[STBUFF_TAG_W-1:0])
    else log_mismatch("cache answer steering");

  a_dc_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!dcache_ans_valid_i || dcache_value_o == dcache_ans_data_i)
      && (!dcache_wup_valid_i || dcache_wup_line_o == dcache_wup_line_i))
    else log_mismatch("cache answer data");

  a_flush_clears : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !vadder_lb_valid_o && !vadder_sb_valid_o)
    else log_mismatch("adder result valid after flush");

  a_reset_clears : assert property (@(posedge clk_i)
    !$past(rst_n_i) |-> !vadder_lb_valid_o && !vadder_sb_valid_o)
    else log_mismatch("adder result valid after reset");

  // --------------------
  // Stimulus

  task automatic drive_idle();
    {lb_vadder_valid_i, sb_vadder_valid_i, lb_vadder_ready_i, sb_vadder_ready_i} = '0;
    {lb_rs1_value_i, lb_imm_value_i, sb_rs1_value_i, sb_imm_value_i} = '0;
    lb_ldtype_i    = LS_BYTE;
    sb_sttype_i    = LS_BYTE;
    sb_dc_sttype_i = LS_BYTE;
    {lb_tag_i, lb_dc_tag_i, sb_tag_i, sb_dc_tag_i} = '0;
    {lb_dcache_valid_i, sb_dcache_valid_i, dcache_ready_i, flush_i} = '0;
    {lb_paddr_i, sb_paddr_i, sb_value_i, dcache_ans_data_i, dcache_wup_line_i} = '0;
    {dcache_ans_valid_i, dcache_wup_valid_i, dcache_was_store_i} = '0;
    {lb_dc_ans_ready_i, sb_dc_ans_ready_i} = '0;
    dcache_ans_idx_i = '0;
  endtask

  // A pending request keeps its fields until it is taken
  task automatic drive_cycle();
    logic [63:0] r;
    if (!lb_vadder_valid_i || lb_va_done) begin
      r = rand_bits(4);
      lb_vadder_valid_i = r[0];
      lb_ldtype_i       = pick_type(r[3:1]);
      lb_rs1_value_i    = rand_bits(64);
      lb_imm_value_i    = rand_bits(64);
      r = rand_bits(LDBUFF_TAG_W);
      lb_tag_i = r[LDBUFF_TAG_W-1:0];
    end
    if (!sb_vadder_valid_i || sb_va_done) begin
      r = rand_bits(4 + STBUFF_TAG_W);
      sb_vadder_valid_i = r[0];
      sb_sttype_i       = pick_type(r[3:1]);
      sb_tag_i          = r[4 +: STBUFF_TAG_W];
      sb_rs1_value_i    = rand_bits(64);
      sb_imm_value_i    = rand_bits(64);
    end
    if (!lb_dcache_valid_i || lb_dc_done) begin
      r = rand_bits(1 + LDBUFF_TAG_W);
      lb_dcache_valid_i = r[0];
      lb_dc_tag_i       = r[1 +: LDBUFF_TAG_W];
      lb_paddr_i        = rand_bits(64);
    end
    if (!sb_dcache_valid_i || sb_dc_done) begin
      r = rand_bits(4 + STBUFF_TAG_W);
      sb_dcache_valid_i = r[0];
      sb_dc_sttype_i    = pick_type(r[3:1]);
      sb_dc_tag_i       = r[4 +: STBUFF_TAG_W];
      sb_paddr_i        = rand_bits(64);
      sb_value_i        = rand_bits(64);
    end
    r = rand_bits(3 + BUFF_IDX_LEN);
    dcache_ans_valid_i = r[0];
    dcache_wup_valid_i = r[1] & ~r[0];
    dcache_was_store_i = r[2];
    dcache_ans_idx_i   = r[3 +: BUFF_IDX_LEN];
    dcache_ans_data_i  = rand_bits(64);
    dcache_wup_line_i  = rand_bits(64);
    r = rand_bits(10);
    lb_vadder_ready_i = r[0];
    sb_vadder_ready_i = r[1];
    dcache_ready_i    = r[2];
    lb_dc_ans_ready_i = r[3];
    sb_dc_ans_ready_i = r[4];
    flush_i           = &r[9:5];
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    lfsr_q      = LFSR_SEED;
    error_count = 0;
    drive_idle();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (TEST_CYCLES) begin
      @(negedge clk_i);
      drive_cycle();
    end
    @(negedge clk_i);
    drive_idle();
    repeat (2) @(negedge clk_i);
    $display("Run of %0d cycles finished with %0d errors", TEST_CYCLES, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire
